// File: rtl/cart_header_scan.sv
// Only writes of a cartridge download are scanned; results stay until the next download starts
`default_nettype none

module cart_header_scan (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               cart_dl,
	input  cart_pkg::dl_word_t dl,
	output logic               hdr_jp,
	output logic               hdr_us,
	output logic               hdr_eu,
	output logic               header_ready,
	output cart_pkg::quirk_t   quirks
);

	import cart_pkg::*;

	logic        old_dl;
	logic        dl_start;
	logic        hdr_wr;
	logic [2:0]  letters_q;
	logic [2:0]  letters_base;
	logic [2:0]  letters_new;
	logic [63:0] id_q;
	quirk_t      quirk_match;

	// One header byte as {jp, us, eu}
	function automatic logic [2:0] letter_flags(input logic [7:0] b);
		logic [2:0] f;
		f = 3'b000;
		if (b == "J")
			f = 3'b100;
		else if (b == "U")
			f = 3'b010;
		else if (b >= "0" && b <= "Z")
			f = 3'b001;
		return f;
	endfunction

	assign dl_start     = cart_dl & ~old_dl;
	assign hdr_wr       = cart_dl & dl.wr;
	assign letters_base = dl_start ? 3'b000 : letters_q;

	always_comb begin
		letters_new = letters_base;
		if (dl.addr == HDR_REGION_ADDR_A)
			letters_new = letters_base | letter_flags(dl.data[15:8])
				| letter_flags(dl.data[7:0]);
		// Third region byte only
		else if (dl.addr == HDR_REGION_ADDR_B)
			letters_new = letters_base | letter_flags(dl.data[7:0]);
	end

	always_comb begin
		quirk_match = '0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (id_q == QUIRK_TABLE[i].id)
				quirk_match = quirk_match | QUIRK_TABLE[i].flags;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_dl       <= 1'b0;
			letters_q    <= 3'b000;
			header_ready <= 1'b0;
			quirks       <= '0;
		end else begin
			old_dl <= cart_dl;
			if (dl_start) begin
				letters_q    <= 3'b000;
				header_ready <= 1'b0;
				quirks       <= '0;
			end
			if (old_dl && !cart_dl)
				header_ready <= 1'b0;
			if (hdr_wr) begin
				letters_q <= letters_new;
				if (dl.addr == HDR_ID_CHECK_ADDR)
					quirks <= quirk_match;
				if (dl.addr == HDR_READY_ADDR)
					header_ready <= 1'b1;
			end
		end
	end

	// Product ID, 8 bytes from 0x183 to 0x18A
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (dl.addr)
				HDR_ID_ADDR_0: id_q[63:56] <= dl.data[7:0];
				HDR_ID_ADDR_1: id_q[55:40] <= dl.data;
				HDR_ID_ADDR_2: id_q[39:24] <= dl.data;
				HDR_ID_ADDR_3: id_q[23:8]  <= dl.data;
				HDR_ID_ADDR_4: id_q[7:0]   <= dl.data[15:8];
				default: ;
			endcase
		end
	end

	assign {hdr_jp, hdr_us, hdr_eu} = letters_q;

endmodule

`default_nettype wire

// File: rtl/cart_loader_top.sv
// Index 0xFF selects a cheat download, any other index a cartridge; reads pass through in one cycle
`default_nettype none

module cart_loader_top (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  cart_pkg::dl_word_t   dl,
	input  logic                 dl_active,
	input  cart_pkg::cart_cfg_t  cfg,
	input  logic                 cheat_enable,
	input  logic                 rom_wrack,
	input  cheat_pkg::rom_read_t rd,
	output logic                 dl_wait,
	output logic                 rom_wr,
	output logic [24:0]          rom_wr_addr,
	output logic [15:0]          rom_wr_data,
	output logic [24:0]          rom_size,
	output cart_pkg::quirk_t     quirks,
	output cart_pkg::region_t    region,
	output logic                 region_valid,
	output logic                 cheats_available,
	output cheat_pkg::rom_read_t patched
);

	import cart_pkg::*;
	import cheat_pkg::*;

	logic                   cart_dl;
	logic                   code_dl;
	logic                   hdr_jp;
	logic                   hdr_us;
	logic                   hdr_eu;
	logic                   header_ready;
	cheat_code_t            code;
	logic [CHEAT_SLOTS-1:0] load_sel;
	logic                   clear_all;
	logic [CHEAT_SLOTS-1:0] loaded;
	slot_hit_t              hits [CHEAT_SLOTS];

	assign cart_dl = dl_active & (dl.index != CODE_INDEX);
	assign code_dl = dl_active & (dl.index == CODE_INDEX);

	////////////////////////////////////////
	// Cartridge path
	rom_write_pacer u_pacer (
		.clk_sys(clk_sys), .rst(rst), .dl(dl), .cart_dl(cart_dl), .rom_wrack(rom_wrack),
		.dl_wait(dl_wait), .rom_wr(rom_wr), .rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data), .rom_size(rom_size)
	);

	cart_header_scan u_hdr (
		.clk_sys(clk_sys), .rst(rst), .cart_dl(cart_dl), .dl(dl),
		.hdr_jp(hdr_jp), .hdr_us(hdr_us), .hdr_eu(hdr_eu),
		.header_ready(header_ready), .quirks(quirks)
	);

	region_select u_region (
		.clk_sys(clk_sys), .rst(rst), .cfg(cfg), .dl_index(dl.index),
		.hdr_jp(hdr_jp), .hdr_us(hdr_us), .hdr_eu(hdr_eu),
		.header_ready(header_ready), .region(region), .region_valid(region_valid)
	);

	////////////////////////////////////////
	// Cheat path
	cheat_code_loader u_code_loader (
		.clk_sys(clk_sys), .rst(rst), .dl(dl), .code_dl(code_dl),
		.code(code), .load_sel(load_sel), .clear_all(clear_all)
	);

	for (genvar i = 0; i < CHEAT_SLOTS; i++) begin : g_slot
		cheat_slot u_slot (
			.clk_sys(clk_sys), .rst(rst), .clear_all(clear_all), .load(load_sel[i]),
			.code(code), .rd(rd), .loaded(loaded[i]), .hit(hits[i])
		);
	end

	assign cheats_available = |loaded;

	cheat_patch_merge u_merge (
		.clk_sys(clk_sys), .rst(rst), .rd(rd), .hits(hits),
		.cheat_enable(cheat_enable), .patched(patched)
	);

endmodule

`default_nettype wire

// File: rtl/cart_pkg.sv
// Cartridge download layout and header map; data words carry the lower file byte in bits 15:8
`default_nettype none

package cart_pkg;

	// One write from the loader, byte address
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
		logic [7:0]  index;
	} dl_word_t;

	localparam logic [7:0] CODE_INDEX = 8'hFF;

	////////////////////////////////////////
	// Header word addresses
	localparam logic [24:0] HDR_REGION_ADDR_A = 25'h1F0;
	localparam logic [24:0] HDR_REGION_ADDR_B = 25'h1F2;
	localparam logic [24:0] HDR_READY_ADDR    = 25'h200;
	localparam logic [24:0] HDR_ID_ADDR_0     = 25'h182;
	localparam logic [24:0] HDR_ID_ADDR_1     = 25'h184;
	localparam logic [24:0] HDR_ID_ADDR_2     = 25'h186;
	localparam logic [24:0] HDR_ID_ADDR_3     = 25'h188;
	localparam logic [24:0] HDR_ID_ADDR_4     = 25'h18A;
	localparam logic [24:0] HDR_ID_CHECK_ADDR = 25'h18C;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	// User options; prio picks one of four region orders
	typedef struct packed {
		logic       auto_enable;
		logic       from_header;
		logic [1:0] prio;
	} cart_cfg_t;

	////////////////////////////////////////
	// Per-title quirks, one product ID each
	typedef struct packed {
		logic [63:0] id;
		quirk_t      flags;
	} quirk_entry_t;

	localparam int QUIRK_COUNT = 8;

	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{id: "T-081276", flags: '{sram: 1'b1, default: 1'b0}},
		'{id: "MK-1215 ", flags: '{eeprom: 1'b1, default: 1'b0}},
		'{id: "T-113016", flags: '{noram: 1'b1, default: 1'b0}},
		'{id: "T-89016 ", flags: '{fifo: 1'b1, default: 1'b0}},
		'{id: "T-574023", flags: '{pier: 1'b1, default: 1'b0}},
		'{id: "MK-1229 ", flags: '{svp: 1'b1, default: 1'b0}},
		'{id: "T-35036 ", flags: '{fmbusy: 1'b1, default: 1'b0}},
		'{id: "T-68???-", flags: '{schan: 1'b1, default: 1'b0}}
	};

endpackage

`default_nettype wire

// File: rtl/cheat_code_loader.sv
// Codes arrive as 16-byte records; a write to address 0 restarts the slot list
`default_nettype none

module cheat_code_loader (
	input  logic                                   clk_sys,
	input  logic                                   rst,
	input  cart_pkg::dl_word_t                     dl,
	input  logic                                   code_dl,
	output cheat_pkg::cheat_code_t                 code,
	output logic [cheat_pkg::CHEAT_SLOTS-1:0]      load_sel,
	output logic                                   clear_all
);

	import cheat_pkg::*;

	logic                         code_wr;
	logic                         commit;
	logic [31:0]                  flags_q;
	logic [31:0]                  addr_q;
	logic [31:0]                  cmp_q;
	logic [15:0]                  rep_lo_q;
	logic [$clog2(CHEAT_SLOTS):0] next_free;

	assign code_wr   = code_dl & dl.wr;
	assign clear_all = code_wr & (dl.addr == '0);
	assign commit    = code_wr & (dl.addr[3:0] == 4'd14);

	// Last word goes straight into the slot
	assign code = '{flags: flags_q, address: addr_q, compare: cmp_q,
		replace: {dl.data, rep_lo_q}};

	always_comb begin
		load_sel = '0;
		if (commit && next_free < CHEAT_SLOTS)
			load_sel[next_free[$clog2(CHEAT_SLOTS)-1:0]] = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  flags_q[15:0]  <= dl.data;
				4'd2:  flags_q[31:16] <= dl.data;
				4'd4:  addr_q[15:0]   <= dl.data;
				4'd6:  addr_q[31:16]  <= dl.data;
				4'd8:  cmp_q[15:0]    <= dl.data;
				4'd10: cmp_q[31:16]   <= dl.data;
				4'd12: rep_lo_q       <= dl.data;
				default: ;
			endcase
		end
	end

	// Slot allocation, extra codes are dropped once full
	always_ff @(posedge clk_sys) begin
		if (rst || clear_all)
			next_free <= '0;
		else if (commit && next_free < CHEAT_SLOTS)
			next_free <= next_free + 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/cheat_patch_merge.sv
// Fixed one-cycle read latency; the lowest-numbered hitting slot wins
`default_nettype none

module cheat_patch_merge (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  cheat_pkg::rom_read_t rd,
	input  cheat_pkg::slot_hit_t hits [cheat_pkg::CHEAT_SLOTS],
	input  logic                 cheat_enable,
	output cheat_pkg::rom_read_t patched
);

	import cheat_pkg::*;

	logic        any_hit;
	logic [15:0] hit_data;
	logic        valid_q;
	logic [23:0] addr_q;
	logic [15:0] data_q;

	// Walk down so slot 0 ends up on top
	always_comb begin
		any_hit  = 1'b0;
		hit_data = '0;
		for (int i = CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (hits[i].hit) begin
				any_hit  = 1'b1;
				hit_data = hits[i].data;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= rd.valid;
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= rd.addr;
		data_q <= (cheat_enable && any_hit) ? hit_data : rd.data;
	end

	assign patched = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/cheat_pkg.sv
// Cheat code layout and ROM read types; only bits 24:1 of a code address take part in a match
`default_nettype none

package cheat_pkg;

	localparam int CHEAT_SLOTS = 4;

	// Flags bit 0 enables the compare value
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ROM read, word address
	typedef struct packed {
		logic        valid;
		logic [23:0] addr;
		logic [15:0] data;
	} rom_read_t;

	typedef struct packed {
		logic        hit;
		logic [15:0] data;
	} slot_hit_t;

endpackage

`default_nettype wire

// File: rtl/cheat_slot.sv
// Hit output is combinational on rd and counts only for valid reads
`default_nettype none

module cheat_slot (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   clear_all,
	input  logic                   load,
	input  cheat_pkg::cheat_code_t code,
	input  cheat_pkg::rom_read_t   rd,
	output logic                   loaded,
	output cheat_pkg::slot_hit_t   hit
);

	logic [23:0] match_addr;
	logic        cmp_en;
	logic [15:0] cmp_val;
	logic [15:0] rep_val;
	logic        addr_eq;
	logic        data_ok;

	always_ff @(posedge clk_sys) begin
		if (rst || clear_all)
			loaded <= 1'b0;
		else if (load)
			loaded <= 1'b1;
	end

	// Only the fields used for matching are kept
	always_ff @(posedge clk_sys) begin
		if (load) begin
			match_addr <= code.address[24:1];
			cmp_en     <= code.flags[0];
			cmp_val    <= code.compare[15:0];
			rep_val    <= code.replace[15:0];
		end
	end

	assign addr_eq = (match_addr == rd.addr);
	assign data_ok = !cmp_en || (cmp_val == rd.data);

	assign hit.hit  = loaded & rd.valid & addr_eq & data_ok;
	assign hit.data = rep_val;

endmodule

`default_nettype wire

// File: rtl/region_select.sv
// Region is decided once per header; dl_index must still hold the download index at that point
`default_nettype none

module region_select (
	input  logic                clk_sys,
	input  logic                rst,
	input  cart_pkg::cart_cfg_t cfg,
	input  logic [7:0]          dl_index,
	input  logic                hdr_jp,
	input  logic                hdr_us,
	input  logic                hdr_eu,
	input  logic                header_ready,
	output cart_pkg::region_t   region,
	output logic                region_valid
);

	import cart_pkg::*;

	logic    old_ready;
	region_t hdr_pick;

	// Priority orders, first letter found wins
	always_comb begin
		case (cfg.prio)
			2'd0: hdr_pick = hdr_us ? US : hdr_eu ? EU : hdr_jp ? JP : US;
			2'd1: hdr_pick = hdr_eu ? EU : hdr_us ? US : hdr_jp ? JP : EU;
			2'd2: hdr_pick = hdr_us ? US : hdr_jp ? JP : hdr_eu ? EU : US;
			default: hdr_pick = hdr_jp ? JP : hdr_us ? US : hdr_eu ? EU : JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_ready    <= 1'b0;
			region       <= JP;
			region_valid <= 1'b0;
		end else begin
			old_ready <= header_ready;
			if (header_ready && !old_ready && cfg.auto_enable) begin
				if (cfg.from_header) begin
					region       <= hdr_pick;
					region_valid <= 1'b1;
				end else begin
					// File type index carries the region in its top bits
					region       <= region_t'(dl_index[7:6]);
					region_valid <= |dl_index;
				end
			end
			if (old_ready && !header_ready)
				region_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rom_write_pacer.sv
// Loader must not write while dl_wait is high; each rom_wr flip is answered by one rom_wrack flip
`default_nettype none

module rom_write_pacer (
	input  logic               clk_sys,
	input  logic               rst,
	input  cart_pkg::dl_word_t dl,
	input  logic               cart_dl,
	input  logic               rom_wrack,
	output logic               dl_wait,
	output logic               rom_wr,
	output logic [24:0]        rom_wr_addr,
	output logic [15:0]        rom_wr_data,
	output logic [24:0]        rom_size
);

	logic old_dl;
	logic dl_start;
	logic wr_base;

	assign dl_start = cart_dl & ~old_dl;
	// Toggle restarts from zero on each new download
	assign wr_base  = dl_start ? 1'b0 : rom_wr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_dl   <= 1'b0;
			dl_wait  <= 1'b0;
			rom_wr   <= 1'b0;
			rom_size <= '0;
		end else begin
			old_dl <= cart_dl;
			if (cart_dl && dl.wr) begin
				rom_wr  <= ~wr_base;
				dl_wait <= 1'b1;
			end else if (dl_start) begin
				rom_wr <= 1'b0;
			end else if (dl_wait && (rom_wr == rom_wrack)) begin
				dl_wait <= 1'b0;
			end
			// End of download, last address is the size
			if (old_dl && !cart_dl) begin
				rom_size <= dl.addr;
				dl_wait  <= 1'b0;
			end
		end
	end

	// Address and data held with the request, bytes swapped for the memory
	always_ff @(posedge clk_sys) begin
		if (cart_dl && dl.wr) begin
			rom_wr_addr <= dl.addr;
			rom_wr_data <= {dl.data[7:0], dl.data[15:8]};
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cartridge loader testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_cart_loader -Mdir obj_dir -o tb_cart_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cart_loader > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
exit 1

// File: sim.f
rtl/cart_pkg.sv
rtl/cheat_pkg.sv
rtl/rom_write_pacer.sv
rtl/cart_header_scan.sv
rtl/region_select.sv
rtl/cheat_code_loader.sv
rtl/cheat_slot.sv
rtl/cheat_patch_merge.sv
rtl/cart_loader_top.sv
sim/cart_loader_properties.sv
sim/tb_cart_loader.sv

// File: sim/cart_loader_properties.sv
// Bound into cart_loader_top; header_ready is taken from the top level's internal net
`default_nettype none

module cart_loader_properties (
	input logic                 clk_sys,
	input logic                 rst,
	input cart_pkg::dl_word_t   dl,
	input logic                 dl_active,
	input logic                 dl_wait,
	input cheat_pkg::rom_read_t rd,
	input cheat_pkg::rom_read_t patched,
	input logic                 region_valid,
	input logic                 header_ready
);

	import cart_pkg::*;

	logic cart_dl;

	assign cart_dl = dl_active && (dl.index != CODE_INDEX);

	////////////////////////////////////////
	// Wait flag clears one edge after the download ends
	a_wait_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		(!cart_dl && !$past(cart_dl)) |-> !dl_wait)
		else $error("dl_wait high outside a cartridge download");

	// Read path latency
	a_read_latency: assert property (@(posedge clk_sys) disable iff (rst)
		patched.valid == $past(rd.valid))
		else $error("patched.valid does not follow rd.valid by one cycle");

	a_region_header: assert property (@(posedge clk_sys) disable iff (rst)
		region_valid |-> (header_ready || $past(header_ready)))
		else $error("region_valid without a ready header");

endmodule

bind cart_loader_top cart_loader_properties u_props (
	.clk_sys(clk_sys), .rst(rst), .dl(dl), .dl_active(dl_active), .dl_wait(dl_wait),
	.rd(rd), .patched(patched), .region_valid(region_valid), .header_ready(header_ready)
);

`default_nettype wire

// File: sim/tb_cart_loader.sv
// Memory model answers writes after 1 to 5 cycles; reads use word addresses 0..15 only
`default_nettype none

module tb_cart_loader;

	import cart_pkg::*;
	import cheat_pkg::*;

	logic        clk_sys = 1'b0;
	logic        rst;
	dl_word_t    dl;
	logic        dl_active;
	cart_cfg_t   cfg;
	logic        cheat_enable;
	logic        rom_wrack = 1'b0;
	rom_read_t   rd;
	logic        dl_wait;
	logic        rom_wr;
	logic [24:0] rom_wr_addr;
	logic [15:0] rom_wr_data;
	logic [24:0] rom_size;
	quirk_t      quirks;
	region_t     region;
	logic        region_valid;
	logic        cheats_available;
	rom_read_t   patched;

	integer seed = 32'hc46b5908;
	int     errors = 0;
	int     timeouts = 0;

	// Memory model state
	logic [15:0] mem [logic [24:0]];
	int          wr_seen;
	logic        ack_busy;
	int          ack_cnt;
	logic        old_active;

	// Cheat slot model
	logic [23:0] s_addr [4];
	logic        s_en [4];
	logic [15:0] s_cmp [4];
	logic [15:0] s_rep [4];
	int          kept;

	logic [63:0] id_list [8] = '{"T-081276", "MK-1215 ", "T-113016", "T-89016 ",
		"T-574023", "MK-1229 ", "T-35036 ", "T-68???-"};
	logic [7:0]  letter_pool [6] = '{"J", "U", "E", "7", ".", "a"};

	cart_loader_top u_cart_loader_top (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (rst) begin
			ack_busy = 1'b0;
			ack_cnt = 0;
			old_active = 1'b0;
			rom_wrack <= 1'b0;
		end else begin
			// Request toggle restarts from zero with each cartridge download
			if (dl_active && !old_active && dl.index != CODE_INDEX) begin
				rom_wrack <= 1'b0;
			end else if (ack_busy) begin
				ack_cnt = ack_cnt - 1;
				if (ack_cnt == 0) begin
					rom_wrack <= ~rom_wrack;
					ack_busy = 1'b0;
				end
			end else if (rom_wr != rom_wrack) begin
				mem[rom_wr_addr] = rom_wr_data;
				wr_seen++;
				ack_busy = 1'b1;
				ack_cnt = 1 + $unsigned($random(seed)) % 5;
			end
			old_active = dl_active;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// Header byte as {jp, us, eu}
	function automatic logic [2:0] letter_bits(input logic [7:0] b);
		if (b == "J")
			return 3'b100;
		if (b == "U")
			return 3'b010;
		if (b >= "0" && b <= "Z")
			return 3'b001;
		return 3'b000;
	endfunction

	function automatic logic [1:0] pick_region(input logic [1:0] prio, input logic [2:0] l);
		case (prio)
			2'd0: return l[1] ? 2'd1 : l[0] ? 2'd2 : l[2] ? 2'd0 : 2'd1;
			2'd1: return l[0] ? 2'd2 : l[1] ? 2'd1 : l[2] ? 2'd0 : 2'd2;
			2'd2: return l[1] ? 2'd1 : l[2] ? 2'd0 : l[0] ? 2'd2 : 2'd1;
			default: return l[2] ? 2'd0 : l[1] ? 2'd1 : l[0] ? 2'd2 : 2'd0;
		endcase
	endfunction

	task automatic cart_download(input int k);
		logic [15:0] img [288];
		logic [7:0]  idx;
		logic [63:0] id;
		logic [7:0]  l0;
		logic [7:0]  l1;
		logic [7:0]  l2;
		logic [2:0]  lbits;
		logic        fh;
		int          nwords;
		int          t;
		nwords = 260 + $unsigned($random(seed)) % 28;
		for (int i = 0; i < 288; i++)
			img[i] = $random(seed);
		id = (k < 8) ? id_list[k] : {$random(seed), $random(seed)};
		img[8'hC1][7:0] = id[63:56];
		img[8'hC2] = id[55:40];
		img[8'hC3] = id[39:24];
		img[8'hC4] = id[23:8];
		img[8'hC5][15:8] = id[7:0];
		l0 = letter_pool[$unsigned($random(seed)) % 6];
		l1 = letter_pool[$unsigned($random(seed)) % 6];
		l2 = letter_pool[$unsigned($random(seed)) % 6];
		img[8'hF8] = {l0, l1};
		img[8'hF9][7:0] = l2;
		lbits = letter_bits(l0) | letter_bits(l1) | letter_bits(l2);
		idx = $random(seed);
		if (idx == CODE_INDEX)
			idx = 8'hFE;
		fh = ((k / 4) % 2) == 0;
		wr_seen = 0;
		mem.delete();

		@(posedge clk_sys);
		dl <= '{wr: 1'b0, addr: '0, data: '0, index: idx};
		dl_active <= 1'b1;
		cfg <= cart_cfg_t'{1'b1, fh, 2'(k % 4)};
		@(posedge clk_sys);
		for (int i = 0; i < nwords; i++) begin
			dl <= '{wr: 1'b1, addr: 25'(2 * i), data: img[i], index: idx};
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			t = 0;
			do begin
				@(negedge clk_sys);
				t++;
			end while (dl_wait && t < 50);
			if (dl_wait) begin
				timeouts++;
				$display("Timeout: no write acknowledge for word %0d of download %0d", i, k);
				return;
			end
			@(posedge clk_sys);
		end

		@(negedge clk_sys);
		check("quirks", quirks, (k < 8) ? (8'h80 >> k) : 8'h00);
		check("region_valid", region_valid, fh ? 1'b1 : (idx != 8'h00));
		if (fh)
			check("region", region, pick_region(2'(k % 4), lbits));
		else if (idx != 8'h00)
			check("region", region, idx[7:6]);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_size", rom_size, 2 * (nwords - 1));
		check("region_valid", region_valid, 1'b0);
		check("write count", wr_seen, nwords);
		for (int i = 0; i < nwords; i++) begin
			if (!mem.exists(25'(2 * i))) begin
				errors++;
				$display("No ROM write reached the memory for byte address %0h", 2 * i);
			end else begin
				check("rom write", mem[25'(2 * i)], {img[i][7:0], img[i][15:8]});
			end
		end
	endtask

	task automatic cheat_download(input int n);
		logic [15:0] words [8];
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] cmp;
		logic [31:0] rep;
		kept = 0;
		@(posedge clk_sys);
		dl <= '{wr: 1'b0, addr: '0, data: '0, index: CODE_INDEX};
		dl_active <= 1'b1;
		for (int c = 0; c < n; c++) begin
			flags = $random(seed);
			addr = ($random(seed) & 32'hFE00_0001) | ({$unsigned($random(seed)) % 16} << 1);
			cmp = $random(seed);
			rep = $random(seed);
			words = '{flags[15:0], flags[31:16], addr[15:0], addr[31:16],
				cmp[15:0], cmp[31:16], rep[15:0], rep[31:16]};
			for (int o = 0; o < 8; o++) begin
				@(posedge clk_sys);
				dl <= '{wr: 1'b1, addr: 25'(16 * c + 2 * o), data: words[o], index: CODE_INDEX};
			end
			if (kept < 4) begin
				s_addr[kept] = addr[24:1];
				s_en[kept] = flags[0];
				s_cmp[kept] = cmp[15:0];
				s_rep[kept] = rep[15:0];
				kept++;
			end
		end
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("cheats_available", cheats_available, 1'b1);
	endtask

	task automatic read_test(input int n);
		logic        v;
		logic [23:0] a;
		logic [15:0] d;
		logic        en;
		logic [15:0] exp;
		logic        found;
		logic        prev_valid;
		logic [23:0] prev_addr;
		logic [15:0] prev_data;
		prev_valid = 1'b0;
		prev_addr = '0;
		prev_data = '0;
		for (int i = 0; i <= n; i++) begin
			@(posedge clk_sys);
			v = (i < n) && ($unsigned($random(seed)) % 4 != 0);
			a = 24'($unsigned($random(seed)) % 16);
			d = $random(seed);
			if ($random(seed) & 1)
				d = s_cmp[$unsigned($random(seed)) % kept];
			en = $random(seed);
			rd <= '{valid: v, addr: a, data: d};
			cheat_enable <= en;
			exp = d;
			found = 1'b0;
			for (int j = 0; j < kept; j++) begin
				if (!found && en && s_addr[j] == a && (!s_en[j] || s_cmp[j] == d)) begin
					exp = s_rep[j];
					found = 1'b1;
				end
			end
			@(negedge clk_sys);
			check("patched.valid", patched.valid, prev_valid);
			if (prev_valid) begin
				check("patched.addr", patched.addr, prev_addr);
				check("patched.data", patched.data, prev_data);
			end
			prev_valid = v;
			prev_addr = a;
			prev_data = exp;
		end
	endtask

	initial begin
		int n;
		rst = 1'b1;
		dl = '0;
		dl_active = 1'b0;
		cfg = '0;
		cheat_enable = 1'b0;
		rd = '0;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check("dl_wait", dl_wait, 1'b0);
		check("rom_wr", rom_wr, 1'b0);
		check("region_valid", region_valid, 1'b0);
		check("patched.valid", patched.valid, 1'b0);
		check("cheats_available", cheats_available, 1'b0);
		check("quirks", quirks, 8'h00);

		for (int k = 0; k < 12; k++)
			cart_download(k);

		// Each new code download restarts at offset 0 and clears the slots
		// First one overfills the four slots
		for (int r = 0; r < 3; r++) begin
			if (r == 0)
				n = 5 + $unsigned($random(seed)) % 2;
			else
				n = 1 + $unsigned($random(seed)) % 6;
			cheat_download(n);
			read_test(150);
		end

		$display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
